// File: rtl/jfive_consts.svh
// core-wide width, thread count, opcode and start address constants; include where needed

`ifndef JFIVE_CONSTS_SVH
`define JFIVE_CONSTS_SVH

// datapath and bus widths
`define JFIVE_XLEN              32
`define JFIVE_THREADS           4
`define JFIVE_PC_BITS           32
`define JFIVE_DBUS_ADDR_BITS    10

// thread n starts at n * stride
`define JFIVE_PC_STRIDE         256

// major opcodes of the supported subset
`define JFIVE_OPC_OP            7'b0110011
`define JFIVE_OPC_OPIMM         7'b0010011
`define JFIVE_OPC_BRANCH        7'b1100011
`define JFIVE_OPC_STORE         7'b0100011

`endif

// File: rtl/jfive_pkg.sv
// shared types of the barrel core; import into any module that uses them

`default_nettype none

`include "jfive_consts.svh"

package jfive_pkg;

    typedef logic        [$clog2(`JFIVE_THREADS)-1:0]   id_t;
    typedef logic        [`JFIVE_PC_BITS-1:0]           pc_t;
    typedef logic        [31:0]                         instr_t;
    typedef logic        [4:0]                          ridx_t;
    typedef logic signed [`JFIVE_XLEN-1:0]              rval_t;
    typedef logic        [`JFIVE_DBUS_ADDR_BITS-1:0]    dbus_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // instruction bus response, into decode
    typedef struct packed {
        id_t        id;
        pc_t        pc;
        instr_t     instr;
    } fetch_t;

    // decoded instruction with operands already read
    typedef struct packed {
        id_t        id;
        pc_t        pc;
        logic       rd_en;
        ridx_t      rd_idx;
        rval_t      op_a;
        rval_t      op_b;
        alu_op_t    alu_op;
        logic       is_store;
        rval_t      store_val;
        logic       is_branch;
        logic       branch_ne;
        pc_t        branch_target;
    } dec_t;

endpackage

`default_nettype wire

// File: rtl/jfive_wb_if.sv
// register writeback from execute into the decode register file, one cycle, no handshake

`default_nettype none

interface jfive_wb_if import jfive_pkg::*; ();

    id_t        id;
    logic       rd_en;
    ridx_t      rd_idx;
    rval_t      rd_val;

    modport source (output id, output rd_en, output rd_idx, output rd_val);

    modport sink (input id, input rd_en, input rd_idx, input rd_val);

endinterface

`default_nettype wire

// File: rtl/jfive_pipe_stage.sv
// single-entry valid/wait register slice, reused for any payload type

`default_nettype none

module jfive_pipe_stage
    #(
        parameter type payload_t = logic
    )
    (
        input   var logic       clk,
        input   var logic       rst_n,

        input   var payload_t   s_data,
        input   var logic       s_valid,
        output  var logic       s_wait,

        output  var payload_t   m_data,
        output  var logic       m_valid,
        input   var logic       m_wait
    );

    payload_t   data_q;
    logic       valid_q;

    // full and stalled is the only case that blocks the input
    assign s_wait  = valid_q && m_wait;
    assign m_data  = data_q;
    assign m_valid = valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!s_wait) begin
            valid_q <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid && !s_wait) begin
            data_q <= s_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/jfive_thread_scheduler.sv
// per-thread pc and busy tracking, issues instruction fetch commands round robin

`default_nettype none

`include "jfive_consts.svh"

module jfive_thread_scheduler
    import jfive_pkg::*;
    (
        input   var logic   clk,
        input   var logic   rst_n,

        input   var id_t    retire_id,
        input   var pc_t    retire_pc,
        input   var logic   retire_valid,

        output  var id_t    cmd_id,
        output  var pc_t    cmd_pc,
        output  var logic   cmd_valid,
        input   var logic   cmd_wait
    );

    localparam int THREADS = `JFIVE_THREADS;

    pc_t                    pc_q [THREADS];
    logic   [THREADS-1:0]   busy_q;
    id_t                    rr_q;
    logic                   run_q;
    logic                   hold_q;
    id_t                    hold_id_q;
    id_t                    pick_id;
    logic                   pick_valid;
    logic                   accept;

    // ----------------------------------------------------------------------
    //  selection
    // ----------------------------------------------------------------------

    // walk down so the lowest offset from the pointer wins
    always_comb begin
        pick_id    = rr_q;
        pick_valid = 1'b0;
        for (int i = THREADS - 1; i >= 0; i--) begin
            if (!busy_q[rr_q + id_t'(i)]) begin
                pick_id    = rr_q + id_t'(i);
                pick_valid = 1'b1;
            end
        end
    end

    // nothing is offered until the first edge after reset is released
    // a stalled command keeps its thread even if another one retires meanwhile
    assign cmd_valid = run_q && (hold_q || pick_valid);
    assign cmd_id    = hold_q ? hold_id_q : pick_id;
    assign cmd_pc    = pc_q[cmd_id];
    assign accept    = cmd_valid && !cmd_wait;

    // ----------------------------------------------------------------------
    //  thread state
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
            rr_q   <= '0;
            run_q  <= 1'b0;
            hold_q <= 1'b0;
            for (int i = 0; i < THREADS; i++) begin
                pc_q[i] <= pc_t'(i * `JFIVE_PC_STRIDE);
            end
        end else begin
            run_q  <= 1'b1;
            hold_q <= cmd_valid && cmd_wait;
            if (accept) begin
                busy_q[cmd_id] <= 1'b1;
                rr_q           <= id_t'(cmd_id + 1'b1);
            end
            // retire only ever names a busy thread, never the one being accepted
            if (retire_valid) begin
                busy_q[retire_id] <= 1'b0;
                pc_q[retire_id]   <= retire_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        hold_id_q <= cmd_id;
    end

endmodule

`default_nettype wire

// File: rtl/jfive_decode.sv
// instruction decode with per-thread register files, operands registered toward execute

`default_nettype none

`include "jfive_consts.svh"

module jfive_decode
    import jfive_pkg::*;
    (
        input   var logic       clk,
        input   var logic       rst_n,

        input   var fetch_t     s_data,
        input   var logic       s_valid,
        output  var logic       s_wait,

        jfive_wb_if.sink        wb,

        output  var dec_t       m_data,
        output  var logic       m_valid,
        input   var logic       m_wait
    );

    localparam int REGS = 2 ** $bits(ridx_t);

    rval_t          rf_q [`JFIVE_THREADS][REGS];

    logic   [6:0]   opcode;
    logic   [2:0]   funct3;
    logic   [6:0]   funct7;
    ridx_t          rd;
    ridx_t          rs1;
    ridx_t          rs2;
    rval_t          rs1_val;
    rval_t          rs2_val;
    rval_t          imm_i;
    rval_t          imm_s;
    rval_t          imm_b;
    logic           is_op;
    logic           is_opimm;
    logic           alu_ok;
    dec_t           dec;

    // ----------------------------------------------------------------------
    //  register file
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wb.rd_en && wb.rd_idx != '0) begin
            rf_q[wb.id][wb.rd_idx] <= wb.rd_val;
        end
    end

    // x0 is never written, so force it to read as zero
    assign rs1_val = (rs1 == '0) ? '0 : rf_q[s_data.id][rs1];
    assign rs2_val = (rs2 == '0) ? '0 : rf_q[s_data.id][rs2];

    // ----------------------------------------------------------------------
    //  field extraction
    // ----------------------------------------------------------------------

    assign opcode = s_data.instr[6:0];
    assign rd     = s_data.instr[11:7];
    assign funct3 = s_data.instr[14:12];
    assign rs1    = s_data.instr[19:15];
    assign rs2    = s_data.instr[24:20];
    assign funct7 = s_data.instr[31:25];

    assign imm_i = {{20{s_data.instr[31]}}, s_data.instr[31:20]};
    assign imm_s = {{20{s_data.instr[31]}}, s_data.instr[31:25], s_data.instr[11:7]};
    assign imm_b = {{19{s_data.instr[31]}}, s_data.instr[31], s_data.instr[7],
                    s_data.instr[30:25], s_data.instr[11:8], 1'b0};

    assign is_op    = (opcode == `JFIVE_OPC_OP);
    assign is_opimm = (opcode == `JFIVE_OPC_OPIMM);

    always_comb begin
        alu_ok = 1'b1;
        unique case (funct3)
            3'b000:  dec.alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b100:  dec.alu_op = ALU_XOR;
            3'b110:  dec.alu_op = ALU_OR;
            3'b111:  dec.alu_op = ALU_AND;
            default: begin
                // shifts and slt are outside the subset
                dec.alu_op = ALU_ADD;
                alu_ok     = 1'b0;
            end
        endcase

        // stores always need an add for the address
        if (opcode == `JFIVE_OPC_STORE) begin
            dec.alu_op = ALU_ADD;
        end

        dec.id            = s_data.id;
        dec.pc            = s_data.pc;
        dec.rd_en         = (is_op || is_opimm) && alu_ok && (rd != '0);
        dec.rd_idx        = rd;
        dec.op_a          = rs1_val;
        dec.op_b          = (is_op || opcode == `JFIVE_OPC_BRANCH) ? rs2_val
                          : (opcode == `JFIVE_OPC_STORE)          ? imm_s
                          :                                          imm_i;
        dec.is_store      = (opcode == `JFIVE_OPC_STORE) && (funct3 == 3'b010);
        dec.store_val     = rs2_val;
        dec.is_branch     = (opcode == `JFIVE_OPC_BRANCH) && (funct3[2:1] == 2'b00);
        dec.branch_ne     = funct3[0];
        dec.branch_target = s_data.pc + pc_t'(imm_b);
    end

    // ----------------------------------------------------------------------
    //  decode stage register
    // ----------------------------------------------------------------------

    jfive_pipe_stage
        #(
            .payload_t  (dec_t)
        )
    u_dec_stage
        (
            .clk        (clk),
            .rst_n      (rst_n),
            .s_data     (dec),
            .s_valid    (s_valid),
            .s_wait     (s_wait),
            .m_data     (m_data),
            .m_valid    (m_valid),
            .m_wait     (m_wait)
        );

endmodule

`default_nettype wire

// File: rtl/jfive_execute.sv
// alu, branch resolution and store issue; drives writeback and the retire pulse

`default_nettype none

module jfive_execute
    import jfive_pkg::*;
    (
        input   var logic       clk,
        input   var logic       rst_n,

        input   var dec_t       s_data,
        input   var logic       s_valid,
        output  var logic       s_wait,

        jfive_wb_if.source      wb,

        output  var id_t        retire_id,
        output  var pc_t        retire_pc,
        output  var logic       retire_valid,

        output  var dbus_addr_t st_addr,
        output  var rval_t      st_data,
        output  var logic       st_valid,
        input   var logic       st_wait
    );

    rval_t          alu_res;
    logic           br_taken;
    logic           take;

    logic           exec_valid_q;
    logic           wb_en_q;
    logic           st_valid_q;
    id_t            id_q;
    pc_t            next_pc_q;
    ridx_t          rd_idx_q;
    rval_t          rd_val_q;
    dbus_addr_t     st_addr_q;
    rval_t          st_data_q;

    // ----------------------------------------------------------------------
    //  alu and branch compare
    // ----------------------------------------------------------------------

    always_comb begin
        unique case (s_data.alu_op)
            ALU_SUB: alu_res = s_data.op_a - s_data.op_b;
            ALU_AND: alu_res = s_data.op_a & s_data.op_b;
            ALU_OR:  alu_res = s_data.op_a | s_data.op_b;
            ALU_XOR: alu_res = s_data.op_a ^ s_data.op_b;
            default: alu_res = s_data.op_a + s_data.op_b;
        endcase
    end

    assign br_taken = s_data.is_branch
                   && ((s_data.op_a == s_data.op_b) != s_data.branch_ne);

    // ----------------------------------------------------------------------
    //  result registers
    // ----------------------------------------------------------------------

    // only a store stuck on the data bus holds up the pipe
    assign s_wait = st_valid_q && st_wait;
    assign take   = s_valid && !s_wait;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec_valid_q <= 1'b0;
            wb_en_q      <= 1'b0;
            st_valid_q   <= 1'b0;
        end else begin
            exec_valid_q <= take && !s_data.is_store;
            wb_en_q      <= take && s_data.rd_en;
            st_valid_q   <= take ? s_data.is_store : (st_valid_q && st_wait);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            id_q      <= s_data.id;
            next_pc_q <= br_taken ? s_data.branch_target : s_data.pc + pc_t'(4);
            rd_idx_q  <= s_data.rd_idx;
            rd_val_q  <= alu_res;
            // byte address to word address
            st_addr_q <= alu_res[$bits(dbus_addr_t)+1:2];
            st_data_q <= s_data.store_val;
        end
    end

    assign wb.id     = id_q;
    assign wb.rd_en  = wb_en_q;
    assign wb.rd_idx = rd_idx_q;
    assign wb.rd_val = rd_val_q;

    assign st_addr  = st_addr_q;
    assign st_data  = st_data_q;
    assign st_valid = st_valid_q;

    // a store retires in the cycle the data bus takes it
    assign retire_id    = id_q;
    assign retire_pc    = next_pc_q;
    assign retire_valid = exec_valid_q || (st_valid_q && !st_wait);

endmodule

`default_nettype wire

// File: rtl/jfive_core.sv
// top level of the four-thread barrel core; connect the instruction and data buses here

`default_nettype none

module jfive_core
    import jfive_pkg::*;
    (
        input   var logic       clk,
        input   var logic       rst_n,

        // instruction bus
        output  var id_t        ibus_cmd_id,
        output  var pc_t        ibus_cmd_pc,
        output  var logic       ibus_cmd_valid,
        input   var logic       ibus_cmd_wait,
        input   var id_t        ibus_res_id,
        input   var pc_t        ibus_res_pc,
        input   var instr_t     ibus_res_instr,
        input   var logic       ibus_res_valid,
        output  var logic       ibus_res_wait,

        // data bus, write only
        output  var dbus_addr_t dbus_cmd_addr,
        output  var rval_t      dbus_cmd_wdata,
        output  var logic       dbus_cmd_valid,
        input   var logic       dbus_cmd_wait
    );

    id_t        retire_id;
    pc_t        retire_pc;
    logic       retire_valid;

    fetch_t     res_data;
    fetch_t     if_data;
    logic       if_valid;
    logic       if_wait;

    dec_t       id_data;
    logic       id_valid;
    logic       id_wait;

    jfive_wb_if u_wb ();

    // ----------------------------------------------------------------------
    //  scheduling and fetch
    // ----------------------------------------------------------------------

    jfive_thread_scheduler u_scheduler (
        .clk            (clk),
        .rst_n          (rst_n),
        .retire_id      (retire_id),
        .retire_pc      (retire_pc),
        .retire_valid   (retire_valid),
        .cmd_id         (ibus_cmd_id),
        .cmd_pc         (ibus_cmd_pc),
        .cmd_valid      (ibus_cmd_valid),
        .cmd_wait       (ibus_cmd_wait)
    );

    // the response carries its own id and pc, so order does not matter
    assign res_data = '{id: ibus_res_id, pc: ibus_res_pc, instr: ibus_res_instr};

    jfive_pipe_stage #(.payload_t(fetch_t)) u_fetch_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_data         (res_data),
        .s_valid        (ibus_res_valid),
        .s_wait         (ibus_res_wait),
        .m_data         (if_data),
        .m_valid        (if_valid),
        .m_wait         (if_wait)
    );

    // ----------------------------------------------------------------------
    //  decode and execute
    // ----------------------------------------------------------------------

    jfive_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_data         (if_data),
        .s_valid        (if_valid),
        .s_wait         (if_wait),
        .wb             (u_wb.sink),
        .m_data         (id_data),
        .m_valid        (id_valid),
        .m_wait         (id_wait)
    );

    jfive_execute u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_data         (id_data),
        .s_valid        (id_valid),
        .s_wait         (id_wait),
        .wb             (u_wb.source),
        .retire_id      (retire_id),
        .retire_pc      (retire_pc),
        .retire_valid   (retire_valid),
        .st_addr        (dbus_cmd_addr),
        .st_data        (dbus_cmd_wdata),
        .st_valid       (dbus_cmd_valid),
        .st_wait        (dbus_cmd_wait)
    );

endmodule

`default_nettype wire

// File: sim/tb_jfive_core.sv
// testbench for the barrel core; runs one program per thread and checks fetch order and stores

`default_nettype none

`include "jfive_consts.svh"

module tb_jfive_core import jfive_pkg::*; ();

    localparam int      THREADS      = `JFIVE_THREADS;
    localparam int      MEM_WORDS    = THREADS * `JFIVE_PC_STRIDE / 4;
    localparam int      REGION_WORDS = 64;
    localparam instr_t  SELF_LOOP    = 32'h0000_0063;

    logic       clk;
    logic       rst_n;
    id_t        ibus_cmd_id;
    pc_t        ibus_cmd_pc;
    logic       ibus_cmd_valid;
    logic       ibus_cmd_wait;
    id_t        ibus_res_id;
    pc_t        ibus_res_pc;
    instr_t     ibus_res_instr;
    logic       ibus_res_valid;
    logic       ibus_res_wait;
    dbus_addr_t dbus_cmd_addr;
    rval_t      dbus_cmd_wdata;
    logic       dbus_cmd_valid;
    logic       dbus_cmd_wait;

    integer     seed;
    int         cycles;
    int         limit;
    int         pc_errors;
    int         addr_errors;
    int         data_errors;
    int         other_errors;
    int         wr_ptr;
    int         fetch_cnt [THREADS];
    instr_t     imem [MEM_WORDS];
    fetch_t     pending_q [$];
    pc_t        exp_pc_q [THREADS][$];
    dbus_addr_t exp_addr_q [THREADS][$];
    rval_t      exp_data_q [THREADS][$];
    pc_t        final_pc [THREADS];

    jfive_core UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .ibus_cmd_id    (ibus_cmd_id),
        .ibus_cmd_pc    (ibus_cmd_pc),
        .ibus_cmd_valid (ibus_cmd_valid),
        .ibus_cmd_wait  (ibus_cmd_wait),
        .ibus_res_id    (ibus_res_id),
        .ibus_res_pc    (ibus_res_pc),
        .ibus_res_instr (ibus_res_instr),
        .ibus_res_valid (ibus_res_valid),
        .ibus_res_wait  (ibus_res_wait),
        .dbus_cmd_addr  (dbus_cmd_addr),
        .dbus_cmd_wdata (dbus_cmd_wdata),
        .dbus_cmd_valid (dbus_cmd_valid),
        .dbus_cmd_wait  (dbus_cmd_wait)
    );

    always #4 clk = ~clk;

    // ----------------------------------------------------------------------
    //  instruction encoding and program image
    // ----------------------------------------------------------------------

    function automatic instr_t encode_r(input logic [6:0] f7, input ridx_t rs2,
                                        input ridx_t rs1, input logic [2:0] f3,
                                        input ridx_t rd);
        return {f7, rs2, rs1, f3, rd, `JFIVE_OPC_OP};
    endfunction

    function automatic instr_t encode_i(input int imm, input ridx_t rs1,
                                        input logic [2:0] f3, input ridx_t rd);
        return {imm[11:0], rs1, f3, rd, `JFIVE_OPC_OPIMM};
    endfunction

    function automatic instr_t encode_sw(input int imm, input ridx_t rs2, input ridx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `JFIVE_OPC_STORE};
    endfunction

    function automatic instr_t encode_b(input int imm, input ridx_t rs2,
                                        input ridx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `JFIVE_OPC_BRANCH};
    endfunction

    task automatic place_instr(input instr_t ins);
        imem[wr_ptr] = ins;
        wr_ptr++;
    endtask

    // same shape for every thread, with thread dependent constants
    task automatic load_program(input int tid);
        wr_ptr = tid * `JFIVE_PC_STRIDE / 4;
        place_instr(encode_i(tid * REGION_WORDS * 4, 0, 3'b000, 10));
        place_instr(encode_i(5 + 3 * tid, 0, 3'b000, 1));
        place_instr(encode_i(-7 - tid, 0, 3'b000, 2));
        place_instr(encode_r(7'b0000000, 2, 1, 3'b000, 3));
        place_instr(encode_sw(0, 3, 10));
        place_instr(encode_r(7'b0100000, 2, 1, 3'b000, 4));
        place_instr(encode_sw(4, 4, 10));
        place_instr(encode_r(7'b0000000, 2, 1, 3'b111, 5));
        place_instr(encode_r(7'b0000000, 2, 1, 3'b110, 6));
        place_instr(encode_r(7'b0000000, 2, 1, 3'b100, 7));
        place_instr(encode_sw(8, 5, 10));
        place_instr(encode_sw(12, 6, 10));
        place_instr(encode_sw(16, 7, 10));
        place_instr(encode_i(32'h0f0 | tid, 2, 3'b111, 8));
        place_instr(encode_i(32'h700, 1, 3'b110, 9));
        place_instr(encode_i(-1, 2, 3'b100, 11));
        place_instr(encode_sw(20, 8, 10));
        place_instr(encode_sw(24, 9, 10));
        place_instr(encode_sw(28, 11, 10));
        // x0 must stay zero
        place_instr(encode_i(123, 1, 3'b000, 0));
        place_instr(encode_sw(32, 0, 10));
        place_instr(encode_i(2 + tid, 0, 3'b000, 12));
        place_instr(encode_i(0, 0, 3'b000, 13));
        // loop body, runs 2 + tid times
        place_instr(encode_r(7'b0000000, 1, 13, 3'b000, 13));
        place_instr(encode_i(-1, 12, 3'b000, 12));
        place_instr(encode_sw(36, 13, 10));
        place_instr(encode_b(-12, 0, 12, 3'b001));
        // taken forward skip, then a not-taken branch
        place_instr(encode_b(8, 0, 12, 3'b000));
        place_instr(encode_sw(40, 1, 10));
        place_instr(encode_b(8, 0, 1, 3'b000));
        place_instr(encode_sw(44, 13, 10));
        place_instr(SELF_LOOP);
    endtask

    // ----------------------------------------------------------------------
    //  ISA reference model of one thread
    // ----------------------------------------------------------------------

    function automatic void run_reference(input int tid);
        rval_t      regs [32];
        pc_t        pc;
        pc_t        next;
        instr_t     ins;
        rval_t      a;
        rval_t      b;
        rval_t      res;
        rval_t      sum;
        logic       wr;
        logic       running;
        int         steps;

        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc      = pc_t'(tid * `JFIVE_PC_STRIDE);
        running = 1'b1;
        steps   = 0;
        while (running && steps < 4096) begin
            ins = imem[int'(pc >> 2) % MEM_WORDS];
            exp_pc_q[tid].push_back(pc);
            steps++;
            if (ins == SELF_LOOP) begin
                final_pc[tid] = pc;
                running       = 1'b0;
            end else begin
                a    = regs[ins[19:15]];
                b    = regs[ins[24:20]];
                next = pc + pc_t'(4);
                wr   = 1'b0;
                res  = '0;
                case (ins[6:0])
                    `JFIVE_OPC_OP, `JFIVE_OPC_OPIMM: begin
                        if (ins[6:0] == `JFIVE_OPC_OPIMM) begin
                            b = {{20{ins[31]}}, ins[31:20]};
                        end
                        wr = 1'b1;
                        case (ins[14:12])
                            3'b000:  res = (ins[6:0] == `JFIVE_OPC_OP && ins[30]) ? a - b : a + b;
                            3'b100:  res = a ^ b;
                            3'b110:  res = a | b;
                            3'b111:  res = a & b;
                            default: wr = 1'b0;
                        endcase
                    end
                    `JFIVE_OPC_BRANCH: begin
                        if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                            next = pc + pc_t'({{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                               ins[11:8], 1'b0});
                        end
                    end
                    `JFIVE_OPC_STORE: begin
                        if (ins[14:12] == 3'b010) begin
                            sum = a + rval_t'({{20{ins[31]}}, ins[31:25], ins[11:7]});
                            exp_addr_q[tid].push_back(sum[`JFIVE_DBUS_ADDR_BITS+1:2]);
                            exp_data_q[tid].push_back(b);
                        end
                    end
                    default: ;
                endcase
                if (wr && ins[11:7] != 5'd0) begin
                    regs[ins[11:7]] = res;
                end
                pc = next;
            end
        end
    endfunction

    function automatic logic all_done();
        for (int t = 0; t < THREADS; t++) begin
            if (exp_pc_q[t].size() != 0 || exp_addr_q[t].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    //  compare tasks
    // ----------------------------------------------------------------------

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            pc_errors++;
        end
    endtask

    task automatic check_addr(input string name, input dbus_addr_t got, input dbus_addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_val(input string name, input rval_t got, input rval_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
            other_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    //  comparing process
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        int tid;
        if (rst_n && ibus_cmd_valid && !ibus_cmd_wait) begin
            fetch_cnt[ibus_cmd_id]++;
            // the first round must reach every thread once
            if (fetch_cnt[ibus_cmd_id] == 2) begin
                for (int t = 0; t < THREADS; t++) begin
                    if (fetch_cnt[t] == 0) begin
                        $display("thread %0d fetched twice before thread %0d was fetched",
                                 ibus_cmd_id, t);
                        other_errors++;
                    end
                end
            end
            if (exp_pc_q[ibus_cmd_id].size() > 0) begin
                check_pc($sformatf("ibus_cmd_pc[thread %0d]", ibus_cmd_id), ibus_cmd_pc,
                         exp_pc_q[ibus_cmd_id].pop_front());
            end else begin
                check_pc($sformatf("ibus_cmd_pc[thread %0d]", ibus_cmd_id), ibus_cmd_pc,
                         final_pc[ibus_cmd_id]);
            end
        end
        if (rst_n && dbus_cmd_valid && !dbus_cmd_wait) begin
            tid = int'(dbus_cmd_addr) / REGION_WORDS;
            if (tid >= THREADS || exp_addr_q[tid % THREADS].size() == 0) begin
                $display("unexpected store to word address %h at %0t", dbus_cmd_addr, $time);
                other_errors++;
            end else begin
                check_addr($sformatf("dbus_cmd_addr[thread %0d]", tid), dbus_cmd_addr,
                           exp_addr_q[tid].pop_front());
                check_val($sformatf("dbus_cmd_wdata[thread %0d]", tid), dbus_cmd_wdata,
                          exp_data_q[tid].pop_front());
            end
        end
    end

    // ----------------------------------------------------------------------
    //  instruction memory and bus model
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        fetch_t swap;
        fetch_t pick;
        logic   res_taken;
        res_taken = 1'b0;
        if (rst_n) begin
            if (ibus_cmd_valid && !ibus_cmd_wait) begin
                pending_q.push_back('{id: ibus_cmd_id, pc: ibus_cmd_pc, instr: '0});
            end
            res_taken = ibus_res_valid && !ibus_res_wait;
        end
        #1;
        if (res_taken) begin
            ibus_res_valid = 1'b0;
        end
        if (!ibus_res_valid && pending_q.size() > 0 && ($random(seed) & 1)) begin
            // now and then answer the younger request first
            if (pending_q.size() > 1 && (($random(seed) & 3) == 0)) begin
                swap         = pending_q[0];
                pending_q[0] = pending_q[1];
                pending_q[1] = swap;
            end
            pick           = pending_q.pop_front();
            ibus_res_id    = pick.id;
            ibus_res_pc    = pick.pc;
            ibus_res_instr = imem[int'(pick.pc >> 2) % MEM_WORDS];
            ibus_res_valid = 1'b1;
        end
        ibus_cmd_wait = (($random(seed) & 3) == 0);
        dbus_cmd_wait = (($random(seed) & 7) < 3);
    end

    // ----------------------------------------------------------------------
    //  main sequence
    // ----------------------------------------------------------------------

    initial begin
        int total;
        seed           = 32'hd3b4_bdf0;
        clk            = 1'b0;
        rst_n          = 1'b0;
        ibus_cmd_wait  = 1'b0;
        ibus_res_id    = '0;
        ibus_res_pc    = '0;
        ibus_res_instr = '0;
        ibus_res_valid = 1'b0;
        dbus_cmd_wait  = 1'b0;
        pc_errors      = 0;
        addr_errors    = 0;
        data_errors    = 0;
        other_errors   = 0;
        total          = 0;

        // unused words hold no-ops tagged with their own index
        for (int w = 0; w < MEM_WORDS; w++) begin
            imem[w] = encode_i(w, 0, 3'b000, 0);
        end
        for (int t = 0; t < THREADS; t++) begin
            fetch_cnt[t] = 0;
            load_program(t);
        end
        for (int t = 0; t < THREADS; t++) begin
            run_reference(t);
            total += exp_pc_q[t].size();
        end
        limit = 4 * total * 20;

        repeat (3) @(posedge clk);
        check_flag("ibus_cmd_valid", ibus_cmd_valid, 1'b0);
        check_flag("dbus_cmd_valid", dbus_cmd_valid, 1'b0);
        check_flag("ibus_res_wait", ibus_res_wait, 1'b0);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (!all_done() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        if (!all_done()) begin
            $display("timeout after %0d cycles with expected fetches or stores missing", cycles);
            other_errors++;
        end
        $display("errors: pc %0d, store addr %0d, store data %0d, other %0d",
                 pc_errors, addr_errors, data_errors, other_errors);
        if (pc_errors + addr_errors + data_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/jfive_pkg.sv
rtl/jfive_wb_if.sv
rtl/jfive_pipe_stage.sv
rtl/jfive_thread_scheduler.sv
rtl/jfive_decode.sv
rtl/jfive_execute.sv
rtl/jfive_core.sv
sim/tb_jfive_core.sv

// File: Bender.yml
package:
  name: jfive_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/jfive_pkg.sv
      - rtl/jfive_wb_if.sv
      - rtl/jfive_pipe_stage.sv
      - rtl/jfive_thread_scheduler.sv
      - rtl/jfive_decode.sv
      - rtl/jfive_execute.sv
      - rtl/jfive_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_jfive_core.sv
